// File: fetch_pkg.sv
package fetch_pkg;

    localparam int ADDR_W  = 32;
    localparam int DATA_W  = 32;

    // direct mapped, one word per line
    localparam int LINES   = 16;
    localparam int INDEX_W = 4;   // addr[5:2]
    localparam int TAG_W   = 26;  // addr[31:6]

    localparam logic [ADDR_W-1:0] RESET_PC = 32'h0000_0000;

    typedef enum logic [1:0] {
        IDLE,
        COMPARE,
        REFILL,
        RESPOND
    } cache_state_e;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } fetch_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              fault;
    } fetch_resp_t;

    // 65 bits on the outside stream
    typedef struct packed {
        logic [ADDR_W-1:0] pc;
        logic [DATA_W-1:0] instr;
        logic              fault;
    } fetch_packet_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } refill_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              fault;  // bus error, line is not filled
    } refill_resp_t;

endpackage

// File: axi_lite_pkg.sv
package axi_lite_pkg;

    localparam int AXI_ADDR_W = 32;
    localparam int AXI_DATA_W = 32;
    localparam int PROT_W     = 3;

    // arprot: bit 2 instruction, bit 1 non-secure, bit 0 privileged
    localparam logic [PROT_W-1:0] PROT_INSTR = 3'b100;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

    // read address channel payload
    typedef struct packed {
        logic [AXI_ADDR_W-1:0] araddr;
        logic [PROT_W-1:0]     arprot;
    } ar_chan_t;

    // read data channel payload
    typedef struct packed {
        logic [AXI_DATA_W-1:0] rdata;
        axi_resp_e             rresp;
    } r_chan_t;

endpackage

// File: fetch_sequencer.sv
module fetch_sequencer (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             redirect_valid,
    input  logic [fetch_pkg::ADDR_W-1:0]     redirect_pc,
    output logic                             req_valid,
    input  logic                             req_ready,
    output fetch_pkg::fetch_req_t            req,
    input  logic                             resp_valid,
    input  fetch_pkg::fetch_resp_t           resp,
    output logic                             instr_valid,
    input  logic                             instr_ready,
    output fetch_pkg::fetch_packet_t         instr
);

    logic [fetch_pkg::ADDR_W-1:0] pc;
    logic [fetch_pkg::ADDR_W-1:0] req_pc;     // pc of the request in flight
    logic                         running;    // no request while coming out of reset
    logic                         in_flight;
    logic                         stale;
    logic                         slot_valid;
    fetch_pkg::fetch_packet_t     slot;
    logic                         slot_free;

    // the slot is empty by the time the answer arrives
    assign slot_free = !slot_valid || instr_ready;
    assign req_valid = running && !in_flight && slot_free && !redirect_valid;
    assign req.addr  = pc;

    assign instr_valid = slot_valid;
    assign instr       = slot;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc         <= fetch_pkg::RESET_PC;
            running    <= 1'b0;
            in_flight  <= 1'b0;
            stale      <= 1'b0;
            slot_valid <= 1'b0;
        end
        else if (redirect_valid)
        begin
            pc         <= redirect_pc;
            running    <= 1'b1;
            slot_valid <= 1'b0;
            in_flight  <= in_flight && !resp_valid;
            stale      <= in_flight && !resp_valid;  // drop what comes back
        end
        else
        begin
            running <= 1'b1;
            if (req_valid && req_ready)
            begin
                pc        <= pc + 32'd4;
                in_flight <= 1'b1;
            end
            if (instr_valid && instr_ready)
                slot_valid <= 1'b0;
            if (resp_valid)
            begin
                in_flight <= 1'b0;
                stale     <= 1'b0;
                if (!stale)
                    slot_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (req_valid && req_ready)
            req_pc <= pc;
        if (resp_valid && !stale && !redirect_valid)
        begin
            slot.pc    <= req_pc;
            slot.instr <= resp.data;
            slot.fault <= resp.fault;
        end
    end

endmodule

// File: icache.sv
module icache (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     flush,
    input  logic                     req_valid,
    output logic                     req_ready,
    input  fetch_pkg::fetch_req_t    req,
    output logic                     resp_valid,
    output fetch_pkg::fetch_resp_t   resp,
    output logic                     refill_valid,
    input  logic                     refill_ready,
    output fetch_pkg::refill_req_t   refill_req,
    input  logic                     refill_done,
    input  fetch_pkg::refill_resp_t  refill_resp
);

    fetch_pkg::cache_state_e state;
    fetch_pkg::cache_state_e state_next;

    logic [fetch_pkg::LINES-1:0]  valid;
    logic [fetch_pkg::TAG_W-1:0]  tag_mem  [fetch_pkg::LINES];
    logic [fetch_pkg::DATA_W-1:0] data_mem [fetch_pkg::LINES];

    logic [fetch_pkg::ADDR_W-1:0]  addr_q;
    fetch_pkg::refill_resp_t       fill_q;
    logic                          refill_sent;  // request taken, waiting for done
    logic [fetch_pkg::INDEX_W-1:0] index;
    logic [fetch_pkg::TAG_W-1:0]   tag;
    logic                          hit;

    assign index = addr_q[fetch_pkg::INDEX_W+1:2];
    assign tag   = addr_q[fetch_pkg::ADDR_W-1 -: fetch_pkg::TAG_W];
    assign hit   = valid[index] && (tag_mem[index] == tag);

    assign req_ready    = (state == fetch_pkg::IDLE);
    assign refill_valid = (state == fetch_pkg::REFILL) && !refill_sent;
    assign refill_req.addr = {addr_q[fetch_pkg::ADDR_W-1:2], 2'b00};

    // hits answer in COMPARE, misses in RESPOND
    assign resp_valid = ((state == fetch_pkg::COMPARE) && hit) ||
                        (state == fetch_pkg::RESPOND);

    always_comb
    begin
        if (state == fetch_pkg::COMPARE)
        begin
            resp.data  = data_mem[index];
            resp.fault = 1'b0;
        end
        else
        begin
            resp.data  = fill_q.data;
            resp.fault = fill_q.fault;
        end
    end

    always_comb
    begin
        state_next = state;
        case (state)
            fetch_pkg::IDLE:
                if (req_valid)
                    state_next = fetch_pkg::COMPARE;
            fetch_pkg::COMPARE:
                state_next = hit ? fetch_pkg::IDLE : fetch_pkg::REFILL;
            fetch_pkg::REFILL:
                if (refill_done)
                    state_next = fetch_pkg::RESPOND;
            fetch_pkg::RESPOND:
                state_next = fetch_pkg::IDLE;
            default:
                state_next = fetch_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state       <= fetch_pkg::IDLE;
            refill_sent <= 1'b0;
            valid       <= '0;
        end
        else
        begin
            state <= state_next;

            if (refill_valid && refill_ready)
                refill_sent <= 1'b1;
            else if (refill_done)
                refill_sent <= 1'b0;

            if ((state == fetch_pkg::IDLE) && flush)
                valid <= '0;  // invalidate every line
            else if ((state == fetch_pkg::RESPOND) && !fill_q.fault)
                valid[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (req_valid && req_ready)
            addr_q <= req.addr;
        if (refill_done)
            fill_q <= refill_resp;
        // error responses never reach the arrays
        if ((state == fetch_pkg::RESPOND) && !fill_q.fault)
        begin
            tag_mem[index]  <= tag;
            data_mem[index] <= fill_q.data;
        end
    end

endmodule

// File: axi_lite_refill.sv
module axi_lite_refill (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     refill_valid,
    output logic                     refill_ready,
    input  fetch_pkg::refill_req_t   refill_req,
    output logic                     refill_done,
    output fetch_pkg::refill_resp_t  refill_resp,
    output logic                     arvalid,
    input  logic                     arready,
    output axi_lite_pkg::ar_chan_t   ar,
    input  logic                     rvalid,
    output logic                     rready,
    input  axi_lite_pkg::r_chan_t    r
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_AR,
        S_R,
        S_DONE
    } refill_state_e;

    refill_state_e                state;
    logic [fetch_pkg::ADDR_W-1:0] addr_q;
    fetch_pkg::refill_resp_t      resp_q;
    logic                         bus_error;

    assign refill_ready = (state == S_IDLE);
    assign arvalid      = (state == S_AR);
    assign rready       = (state == S_R);
    assign refill_done  = (state == S_DONE);  // one cycle after the R handshake
    assign refill_resp  = resp_q;

    assign ar.araddr = addr_q;
    assign ar.arprot = axi_lite_pkg::PROT_INSTR;

    assign bus_error = !((r.rresp == axi_lite_pkg::OKAY) || (r.rresp == axi_lite_pkg::EXOKAY));

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= S_IDLE;
        else
        begin
            case (state)
                S_IDLE:
                    if (refill_valid)
                        state <= S_AR;
                S_AR:
                    if (arready)
                        state <= S_R;
                S_R:
                    if (rvalid)
                        state <= S_DONE;
                S_DONE:
                    state <= S_IDLE;
                default:
                    state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (refill_valid && refill_ready)
            addr_q <= refill_req.addr;  // held stable for the whole AR phase
        if (rvalid && rready)
        begin
            resp_q.data  <= r.rdata;
            resp_q.fault <= bus_error;
        end
    end

endmodule

// File: ifetch_top.sv
module ifetch_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          redirect_valid,
    input  logic [fetch_pkg::ADDR_W-1:0]  redirect_pc,
    input  logic                          flush,
    output logic                          instr_valid,
    input  logic                          instr_ready,
    output fetch_pkg::fetch_packet_t      instr,
    output logic                          arvalid,
    input  logic                          arready,
    output axi_lite_pkg::ar_chan_t        ar,
    input  logic                          rvalid,
    output logic                          rready,
    input  axi_lite_pkg::r_chan_t         r
);

    // sequencer to cache
    logic                    req_valid;
    logic                    req_ready;
    fetch_pkg::fetch_req_t   req;
    logic                    resp_valid;
    fetch_pkg::fetch_resp_t  resp;

    // cache to refill master
    logic                    refill_valid;
    logic                    refill_ready;
    fetch_pkg::refill_req_t  refill_req;
    logic                    refill_done;
    fetch_pkg::refill_resp_t refill_resp;

    fetch_sequencer u_seq (
        .clk            (clk),
        .rst            (rst),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .req_valid      (req_valid),
        .req_ready      (req_ready),
        .req            (req),
        .resp_valid     (resp_valid),
        .resp           (resp),
        .instr_valid    (instr_valid),
        .instr_ready    (instr_ready),
        .instr          (instr)
    );

    icache u_cache (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req          (req),
        .resp_valid   (resp_valid),
        .resp         (resp),
        .refill_valid (refill_valid),
        .refill_ready (refill_ready),
        .refill_req   (refill_req),
        .refill_done  (refill_done),
        .refill_resp  (refill_resp)
    );

    axi_lite_refill u_refill (
        .clk          (clk),
        .rst          (rst),
        .refill_valid (refill_valid),
        .refill_ready (refill_ready),
        .refill_req   (refill_req),
        .refill_done  (refill_done),
        .refill_resp  (refill_resp),
        .arvalid      (arvalid),
        .arready      (arready),
        .ar           (ar),
        .rvalid       (rvalid),
        .rready       (rready),
        .r            (r)
    );

endmodule

// File: tb_axi_mem.sv
module tb_axi_mem (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [1:0]             delay,    // wait before arready and before rvalid
    input  logic                   arvalid,
    output logic                   arready,
    input  axi_lite_pkg::ar_chan_t ar,
    output logic                   rvalid,
    input  logic                   rready,
    output axi_lite_pkg::r_chan_t  r,
    output int                     ar_count
);

    typedef enum logic [2:0] {
        M_IDLE,
        M_AWAIT,
        M_ADROP,
        M_RWAIT,
        M_RDROP
    } mem_state_e;

    mem_state_e  state;
    logic [1:0]  wait_cnt;
    logic [31:0] addr_q;

    function automatic logic [31:0] word_at(input logic [31:0] addr);
        return (addr ^ 32'hC0DE_0000) + {addr[24:0], addr[31:25]};
    endfunction

    always @(posedge clk)
    begin
        if (rst)
            ar_count <= 0;
        else if (arvalid && arready)
            ar_count <= ar_count + 1;
    end

    // slave outputs move on the falling edge
    always @(negedge clk)
    begin
        if (rst)
        begin
            state   <= M_IDLE;
            arready <= 1'b0;
            rvalid  <= 1'b0;
            r       <= '0;
        end
        else
        begin
            case (state)
                M_IDLE:
                    if (arvalid)
                    begin
                        wait_cnt <= delay;
                        state    <= M_AWAIT;
                    end
                M_AWAIT:
                    if (wait_cnt == 2'd0)
                    begin
                        arready <= 1'b1;  // arvalid is held, handshake on the next rising edge
                        addr_q  <= ar.araddr;
                        state   <= M_ADROP;
                    end
                    else
                        wait_cnt <= wait_cnt - 2'd1;
                M_ADROP:
                begin
                    arready  <= 1'b0;
                    wait_cnt <= delay;
                    state    <= M_RWAIT;
                end
                M_RWAIT:
                    if (wait_cnt != 2'd0)
                        wait_cnt <= wait_cnt - 2'd1;
                    else if (rready)
                    begin
                        rvalid <= 1'b1;
                        if (addr_q >= 32'h0000_F000)
                        begin
                            r.rdata <= '0;  // error region
                            r.rresp <= axi_lite_pkg::SLVERR;
                        end
                        else
                        begin
                            r.rdata <= word_at(addr_q);
                            r.rresp <= axi_lite_pkg::OKAY;
                        end
                        state <= M_RDROP;
                    end
                M_RDROP:
                begin
                    rvalid <= 1'b0;
                    state  <= M_IDLE;
                end
                default:
                    state <= M_IDLE;
            endcase
        end
    end

endmodule

// File: tb_ifetch.sv
module tb_ifetch;

    localparam int          NUM_TESTS  = 8;
    localparam int          WAIT_LIMIT = 200;  // cycles per packet or per idle wait
    localparam logic [31:0] LCG_SEED   = 32'h50b8be25;

    typedef struct packed {
        logic [31:0] pc;
        logic        mid_miss;   // miss at detour_pc, then redirect during its refill
        logic [31:0] detour_pc;
        logic [31:0] packets;
        logic        flush_first;
        logic        throttle;   // random instr_ready
        logic [31:0] exp_ar;
        logic        exp_fault;
    } test_row_t;

    logic                         clk;
    logic                         rst;
    logic                         redirect_valid;
    logic [fetch_pkg::ADDR_W-1:0] redirect_pc;
    logic                         flush;
    logic                         instr_valid;
    logic                         instr_ready;
    fetch_pkg::fetch_packet_t     instr;
    logic                         arvalid;
    logic                         arready;
    axi_lite_pkg::ar_chan_t       ar;
    logic                         rvalid;
    logic                         rready;
    axi_lite_pkg::r_chan_t        r;
    int                           ar_count;

    logic [31:0] lcg_state;
    test_row_t   rows [NUM_TESTS];
    string       names [NUM_TESTS];
    int          errors;
    int          timeouts;

    ifetch_top UUT (
        .clk            (clk),
        .rst            (rst),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .flush          (flush),
        .instr_valid    (instr_valid),
        .instr_ready    (instr_ready),
        .instr          (instr),
        .arvalid        (arvalid),
        .arready        (arready),
        .ar             (ar),
        .rvalid         (rvalid),
        .rready         (rready),
        .r              (r)
    );

    tb_axi_mem mem (
        .clk      (clk),
        .rst      (rst),
        .delay    (lcg_state[21:20]),
        .arvalid  (arvalid),
        .arready  (arready),
        .ar       (ar),
        .rvalid   (rvalid),
        .rready   (rready),
        .r        (r),
        .ar_count (ar_count)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    always @(posedge clk)
    begin
        if (rst)
            lcg_state <= LCG_SEED;
        else
            lcg_state <= lcg_next(lcg_state);
    end

    // data is address xor C0DE_0000 plus address rotated left by 7
    function automatic logic [31:0] expected_instr(input logic [31:0] addr);
        return (addr ^ 32'hC0DE_0000) + {addr[24:0], addr[31:25]};
    endfunction

    task automatic load_table;
        names[0] = "cold_seq_100";
        rows[0]  = '{32'h100, 1'b0, 32'h0, 32'd8, 1'b0, 1'b0, 32'd8, 1'b0};
        names[1] = "hit_seq_100";
        rows[1]  = '{32'h100, 1'b0, 32'h0, 32'd8, 1'b0, 1'b0, 32'd0, 1'b0};
        names[2] = "conflict_140";    // same indexes as 100 with another tag
        rows[2]  = '{32'h140, 1'b0, 32'h0, 32'd8, 1'b0, 1'b0, 32'd8, 1'b0};
        names[3] = "flush_refetch_140";
        rows[3]  = '{32'h140, 1'b0, 32'h0, 32'd8, 1'b1, 1'b0, 32'd8, 1'b0};
        names[4] = "backpressure_200";
        rows[4]  = '{32'h200, 1'b0, 32'h0, 32'd16, 1'b0, 1'b1, 32'd16, 1'b0};
        names[5] = "fault_f000";
        rows[5]  = '{32'hF000, 1'b0, 32'h0, 32'd4, 1'b0, 1'b0, 32'd4, 1'b1};
        names[6] = "fault_f000_repeat";
        rows[6]  = '{32'hF000, 1'b0, 32'h0, 32'd4, 1'b0, 1'b0, 32'd4, 1'b1};
        names[7] = "redirect_mid_miss";
        rows[7]  = '{32'h400, 1'b1, 32'h300, 32'd4, 1'b0, 1'b0, 32'd4, 1'b0};
    endtask

    task automatic redirect_to(input logic [31:0] pc);
        @(negedge clk);
        redirect_valid = 1'b1;
        redirect_pc    = pc;
        instr_ready    = 1'b0;
        @(negedge clk);
        redirect_valid = 1'b0;
    endtask

    task automatic wait_detour_ar(input int t);
        int start;
        int waited;
        start  = ar_count;
        waited = 0;
        while ((ar_count == start) && (waited < WAIT_LIMIT))
        begin
            @(negedge clk);
            waited++;
        end
        if (ar_count == start)
        begin
            timeouts++;
            $display("%s: timed out waiting for the AR transfer of the first miss", names[t]);
        end
    endtask

    // fetching starts at the reset pc and parks in the slot
    task automatic verify_reset_fetch;
        int waited;
        instr_ready = 1'b0;
        waited      = 0;
        while (!instr_valid && (waited < WAIT_LIMIT))
        begin
            @(negedge clk);
            waited++;
        end
        if (!instr_valid)
        begin
            timeouts++;
            $display("reset_fetch: timed out waiting for the first packet after reset");
        end
        else
        begin
            assert (instr.pc == fetch_pkg::RESET_PC)
            else
            begin
                errors++;
                $display("FAILED reset_fetch: pc, expected %h, actual %h",
                         fetch_pkg::RESET_PC, instr.pc);
            end
            assert (instr.instr == expected_instr(fetch_pkg::RESET_PC))
            else
            begin
                errors++;
                $display("FAILED reset_fetch: instr, expected %h, actual %h",
                         expected_instr(fetch_pkg::RESET_PC), instr.instr);
            end
            assert (!instr.fault)
            else
            begin
                errors++;
                $display("FAILED reset_fetch: fault, expected 0, actual %b", instr.fault);
            end
        end
    endtask

    task automatic check_packet(input int t, input int n, input fetch_pkg::fetch_packet_t pkt);
        logic [31:0] exp_pc;
        exp_pc = rows[t].pc + n * 4;
        assert (pkt.pc == exp_pc)
        else
        begin
            errors++;
            $display("FAILED %s: pc of packet %0d, expected %h, actual %h",
                     names[t], n, exp_pc, pkt.pc);
        end
        assert (pkt.fault == rows[t].exp_fault)
        else
        begin
            errors++;
            $display("FAILED %s: fault of packet %0d, expected %b, actual %b",
                     names[t], n, rows[t].exp_fault, pkt.fault);
        end
        if (!rows[t].exp_fault)
        begin
            assert (pkt.instr == expected_instr(exp_pc))
            else
            begin
                errors++;
                $display("FAILED %s: instr of packet %0d, expected %h, actual %h",
                         names[t], n, expected_instr(exp_pc), pkt.instr);
            end
        end
    endtask

    task automatic collect_packets(input int t, input int start_ar, output int ar_used);
        int                       got;
        int                       idle;
        logic                     rdy;
        logic                     held_valid;
        fetch_pkg::fetch_packet_t held_pkt;
        got        = 0;
        idle       = 0;
        held_valid = 1'b0;
        held_pkt   = '0;
        ar_used    = 0;
        while ((got < rows[t].packets) && (idle < WAIT_LIMIT))
        begin
            rdy = rows[t].throttle ? lcg_state[16] : 1'b1;
            instr_ready = rdy;
            if (held_valid)
            begin
                // a refused packet stays put
                assert (instr_valid && (instr == held_pkt))
                else
                begin
                    errors++;
                    $display("FAILED %s: held packet, expected %h, actual %h",
                             names[t], held_pkt, instr);
                end
            end
            if (arvalid)
            begin
                // instruction access, unprivileged
                assert (ar.arprot[2] && !ar.arprot[0])
                else
                begin
                    errors++;
                    $display("FAILED %s: arprot, expected 1x0, actual %b",
                             names[t], ar.arprot);
                end
            end
            if (instr_valid && rdy)
            begin
                check_packet(t, got, instr);
                got++;
                idle       = 0;
                held_valid = 1'b0;
                if (got == rows[t].packets)
                    ar_used = ar_count - start_ar;
            end
            else
            begin
                held_valid = instr_valid;
                held_pkt   = instr;
                idle++;
            end
            @(negedge clk);
        end
        if (got < rows[t].packets)
        begin
            timeouts++;
            $display("%s: timed out waiting for packet %0d", names[t], got);
        end
    endtask

    // the next fetch lands in the slot and the whole path goes idle
    task automatic wait_prefetch_parked(input int t);
        int waited;
        instr_ready = 1'b0;
        waited      = 0;
        while (!instr_valid && (waited < WAIT_LIMIT))
        begin
            @(negedge clk);
            waited++;
        end
        if (!instr_valid)
        begin
            timeouts++;
            $display("%s: timed out waiting for the fetch path to go idle", names[t]);
        end
    endtask

    task automatic run_test(input int t);
        int start_ar;
        int ar_used;
        if (rows[t].flush_first)
        begin
            @(negedge clk);
            flush = 1'b1;
            @(negedge clk);
            flush = 1'b0;
        end
        if (rows[t].mid_miss)
        begin
            redirect_to(rows[t].detour_pc);
            wait_detour_ar(t);
        end
        redirect_to(rows[t].pc);
        start_ar = ar_count;
        collect_packets(t, start_ar, ar_used);
        if (timeouts == 0)
        begin
            assert (ar_used == rows[t].exp_ar)
            else
            begin
                errors++;
                $display("FAILED %s: AR transfers, expected %0d, actual %0d",
                         names[t], rows[t].exp_ar, ar_used);
            end
            wait_prefetch_parked(t);
        end
    endtask

    initial
    begin
        clk            = 1'b0;
        rst            = 1'b1;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        flush          = 1'b0;
        instr_ready    = 1'b0;
        errors         = 0;
        timeouts       = 0;
        load_table();
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        verify_reset_fetch();
        for (int t = 0; (t < NUM_TESTS) && (timeouts == 0); t++)
        begin
            run_test(t);
        end
        $display("result: %0d check errors, %0d timeouts", errors, timeouts);
        if ((errors == 0) && (timeouts == 0))
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: ifetch_top.f
fetch_pkg.sv
axi_lite_pkg.sv
fetch_sequencer.sv
icache.sv
axi_lite_refill.sv
ifetch_top.sv
tb_axi_mem.sv
tb_ifetch.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --top-module tb_ifetch -f ifetch_top.f -o sim_ifetch
./obj_dir/sim_ifetch > sim.log 2>&1
cat sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
    exit 0
else
    exit 1
fi
